// File: sim/snes_testdata.txt
# wr mapper feat rom_mask sram_mask addr pa romsel wdata exp_addr exp_acc exp_en
# wr 1 is a write, exp_en bits are msu 213f obc1 cmd nmi retvec br1 br2
0 0 00 3fffff 001fff 008000 00 0 00 008000 1 00
0 0 00 3fffff 001fff 80c123 00 0 00 00c123 1 00
1 0 00 3fffff 001fff 306000 00 1 a5 e00000 1 00
0 0 00 3fffff 001fff 306000 00 1 00 e00000 1 00
1 0 00 3fffff 001fff 306001 00 1 3c e00001 1 00
0 0 00 3fffff 001fff 306001 00 1 00 e00001 1 00
1 0 00 3fffff 001fff 008000 00 0 11 000000 0 00
0 0 18 3fffff 001fff 002000 3f 1 00 000000 0 c0
0 0 00 3fffff 001fff 002bf2 3f 1 00 000000 0 18
0 0 00 3fffff 001fff 002a5a 00 1 00 000000 0 14
0 0 00 3fffff 001fff 002a13 00 1 00 000000 0 12
0 0 00 3fffff 001fff 002a4d 00 1 00 000000 0 11
0 0 00 3fffff 001fff 007900 00 1 00 000000 0 20
0 1 00 3fffff 001fff c12345 00 0 00 20a345 1 00
0 1 00 3fffff 001fff 408000 00 0 00 200000 1 00
1 1 00 3fffff 001fff 700010 00 0 77 e00010 1 00
0 1 00 3fffff 001fff 700010 00 0 00 e00010 1 00
0 2 00 7fffff 001fff c08000 00 0 00 008000 1 00
0 2 00 7fffff 001fff 408000 00 0 00 408000 1 00
0 3 00 3fffff 001fff 808000 00 0 00 000000 0 00
0 0 00 3fffff 000000 306000 00 1 00 000000 0 00

// File: sources.f
common/snes_map_pkg.sv
common/snes_bus_pkg.sv
common/mem_req_if.sv
address/address_decode.sv
address/snes_bus_capture.sv
design/cfg_regs.sv
design/req_fifo.sv
design/mem_port.sv
design/snes_mem_top.sv
sim/tb_snes_mem.sv

// File: Makefile
all: run

build:
	verilator --binary --timing -f sources.f --top-module tb_snes_mem -o tb_snes_mem

run: build
	./obj_dir/tb_snes_mem | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing -f sources.f --top-module tb_snes_mem

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: sim/tb_snes_mem.sv
module tb_snes_mem
  import snes_map_pkg::*, snes_bus_pkg::*;
;

  typedef struct {
    logic       is_write;
    logic [2:0] mapper;
    logic [7:0] feat;
    logic [23:0] rom_mask;
    logic [23:0] sram_mask;
    logic [23:0] addr;
    logic [7:0] pa;
    logic       romsel;
    logic [7:0] wdata;
    logic [23:0] exp_addr;
    logic       exp_acc;
    logic [7:0] exp_en;
  } vec_t;

  logic       CLK;
  logic       rst_n;
  logic       psel, penable, pwrite;
  apb_addr_t  paddr;
  apb_data_t  pwdata, prdata;
  logic       pready, pslverr;
  snes_addr_t snes_addr;
  snes_data_t snes_pa, snes_wdata;
  logic       snes_romsel, snes_rd_n, snes_wr_n;
  logic [7:0] en;
  logic       mem_req, mem_we, mem_ack, rd_valid;
  rom_addr_t  mem_addr, rd_addr;
  snes_data_t mem_wdata, mem_rdata, rd_data;

  vec_t       vecs[$];
  logic [7:0] mem_model [rom_addr_t];
  logic [31:0] lcg_state = 32'd26042;
  logic       hold_ack;
  int         ack_delay;
  int         mismatches;
  int         other_errors;
  int         cycles;
  int         cycle_limit = 1000000;

  snes_mem_top dut0 (
    .CLK, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .snes_addr, .snes_pa, .snes_romsel, .snes_rd_n, .snes_wr_n, .snes_wdata,
    .msu_enable (en[7]), .r213f_enable (en[6]), .obc1_enable (en[5]),
    .snescmd_enable (en[4]), .nmicmd_enable (en[3]), .return_vector_enable (en[2]),
    .branch1_enable (en[1]), .branch2_enable (en[0]),
    .mem_req, .mem_addr, .mem_we, .mem_wdata, .mem_ack, .mem_rdata,
    .rd_valid, .rd_data, .rd_addr
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  function automatic int next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[30:16]);
  endfunction

  // Unwritten bytes follow a pattern of the full address
  function automatic logic [7:0] model_byte(rom_addr_t a);
    if (mem_model.exists(a)) return mem_model[a];
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5a;
  endfunction

  task automatic compare_value(logic [31:0] got, logic [31:0] exp, string what);
    assert (got == exp) else begin
      mismatches++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic apb_write(apb_addr_t a, apb_data_t d);
    @(posedge CLK);
    psel <= 1'b1;
    pwrite <= 1'b1;
    paddr <= a;
    pwdata <= d;
    @(posedge CLK);
    penable <= 1'b1;
    @(posedge CLK);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(apb_addr_t a, output apb_data_t d, output logic err);
    @(posedge CLK);
    psel <= 1'b1;
    pwrite <= 1'b0;
    paddr <= a;
    @(posedge CLK);
    penable <= 1'b1;
    @(posedge CLK);
    d = prdata;
    err = pslverr;
    compare_value(pready, 1'b1, "pready");
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  // Memory model with random ack latency
  always @(posedge CLK) begin
    mem_ack <= 1'b0;
    if (mem_req && !mem_ack && !hold_ack) begin
      if (ack_delay == 0) begin
        mem_ack <= 1'b1;
        mem_rdata <= model_byte(mem_addr);
        if (mem_we) mem_model[mem_addr] = mem_wdata;
        ack_delay <= next_rand() % 6;
      end else begin
        ack_delay <= ack_delay - 1;
      end
    end
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run exceeded %0d cycles", cycle_limit);
      $display("errors: %0d mismatches, %0d other", mismatches, other_errors + 1);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic run_vector(vec_t v);
    logic [7:0] exp_byte;
    apb_write(REG_CTRL, {16'b0, v.feat, 5'b0, v.mapper});
    apb_write(REG_ROM_MASK, {8'b0, v.rom_mask});
    apb_write(REG_SRAM_MASK, {8'b0, v.sram_mask});
    exp_byte = v.is_write ? v.wdata : model_byte(v.exp_addr);
    snes_addr <= v.addr;
    snes_pa <= v.pa;
    snes_romsel <= v.romsel;
    snes_wdata <= v.wdata;
    @(posedge CLK);
    @(posedge CLK);
    compare_value(en, v.exp_en, "enables");
    if (v.is_write) snes_wr_n <= 1'b0;
    else snes_rd_n <= 1'b0;
    @(posedge CLK);
    snes_wr_n <= 1'b1;
    snes_rd_n <= 1'b1;
    if (!v.exp_acc) begin
      repeat (10) begin
        @(posedge CLK);
        assert (!mem_req) else begin
          other_errors++;
          $display("unexpected memory request for address %h", v.addr);
        end
      end
      return;
    end
    while (!mem_req) @(posedge CLK);
    compare_value(mem_addr, v.exp_addr, "mem_addr");
    compare_value(mem_we, v.is_write, "mem_we");
    if (v.is_write) compare_value(mem_wdata, v.wdata, "mem_wdata");
    do @(posedge CLK); while (!(mem_req && mem_ack));
    @(posedge CLK);
    compare_value(rd_valid, !v.is_write, "rd_valid");
    if (!v.is_write) begin
      compare_value(rd_addr, v.exp_addr, "rd_addr");
      compare_value(rd_data, exp_byte, "rd_data");
    end
  endtask

  task automatic check_backpressure();
    apb_data_t d;
    logic      err;
    apb_write(REG_CTRL, 32'h0);
    apb_write(REG_ROM_MASK, 32'h3fffff);
    hold_ack <= 1'b1;
    for (int i = 0; i < 8; i++) begin
      snes_addr <= 24'h008000 + 24'(i);
      snes_rd_n <= 1'b0;
      @(posedge CLK);
      snes_rd_n <= 1'b1;
      @(posedge CLK);
    end
    repeat (4) @(posedge CLK);
    hold_ack <= 1'b0;
    for (int i = 0; i < 6; i++) begin
      while (!mem_req) @(posedge CLK);
      compare_value(mem_addr, 24'h008000 + 24'(i), "queued mem_addr");
      do @(posedge CLK); while (!(mem_req && mem_ack));
      @(posedge CLK);
    end
    repeat (20) begin
      @(posedge CLK);
      assert (!mem_req) else begin
        other_errors++;
        $display("more than six requests issued under back-pressure");
      end
    end
    apb_read(REG_STATUS, d, err);
    compare_value(d, 32'h1, "overflow status");
    apb_write(REG_STATUS, 32'h1);
    apb_read(REG_STATUS, d, err);
    compare_value(d, 32'h0, "cleared status");
  endtask

  initial begin
    int        fd;
    string     line;
    vec_t      v;
    apb_data_t d;
    logic      err;
    rst_n = 1'b0;
    {psel, penable, pwrite} = 3'b000;
    paddr = '0;
    pwdata = '0;
    snes_addr = '0;
    snes_pa = '0;
    snes_romsel = 1'b1;
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
    snes_wdata = '0;
    mem_ack = 1'b0;
    mem_rdata = '0;
    hold_ack = 1'b0;
    ack_delay = 0;
    fd = $fopen("sim/snes_testdata.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open sim/snes_testdata.txt");
      $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
      $display("Simulation FAILED");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) == 0) break;
        if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", v.is_write, v.mapper,
                    v.feat, v.rom_mask, v.sram_mask, v.addr, v.pa, v.romsel, v.wdata,
                    v.exp_addr, v.exp_acc, v.exp_en) == 12) vecs.push_back(v);
      end
      $fclose(fd);
      cycle_limit = vecs.size() * 40 + 200;
      repeat (2) @(posedge CLK);
      rst_n <= 1'b1;
      apb_write(REG_CTRL, 32'h1802);
      apb_write(REG_ROM_MASK, 32'h3fffff);
      apb_write(REG_SRAM_MASK, 32'h1fff);
      apb_read(REG_CTRL, d, err);
      compare_value(d, 32'h1802, "REG_CTRL readback");
      apb_read(REG_ROM_MASK, d, err);
      compare_value(d, 32'h3fffff, "REG_ROM_MASK readback");
      apb_read(REG_SRAM_MASK, d, err);
      compare_value(d, 32'h1fff, "REG_SRAM_MASK readback");
      apb_read(8'h10, d, err);
      compare_value(err, 1'b1, "pslverr at 0x10");
      foreach (vecs[i]) run_vector(vecs[i]);
      check_backpressure();
      $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
        $display("Simulation PASSED");
      end else begin
        $display("Simulation FAILED");
      end
      $finish;
    end
  end

endmodule

// File: design/snes_mem_top.sv
module snes_mem_top
  import snes_map_pkg::*, snes_bus_pkg::*;
(
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  apb_addr_t  paddr,
  input  apb_data_t  pwdata,
  output apb_data_t  prdata,
  output logic       pready,
  output logic       pslverr,
  input  snes_addr_t snes_addr,
  input  snes_data_t snes_pa,
  input  logic       snes_romsel,
  input  logic       snes_rd_n,
  input  logic       snes_wr_n,
  input  snes_data_t snes_wdata,
  output logic       msu_enable,
  output logic       r213f_enable,
  output logic       obc1_enable,
  output logic       snescmd_enable,
  output logic       nmicmd_enable,
  output logic       return_vector_enable,
  output logic       branch1_enable,
  output logic       branch2_enable,
  output logic       mem_req,
  output rom_addr_t  mem_addr,
  output logic       mem_we,
  output snes_data_t mem_wdata,
  input  logic       mem_ack,
  input  snes_data_t mem_rdata,
  output logic       rd_valid,
  output snes_data_t rd_data,
  output rom_addr_t  rd_addr
);

  mapper_e    mapper;
  feature_t   featurebits;
  addr_mask_t rom_mask;
  addr_mask_t saveram_mask;
  logic       overflow;

  mem_req_if cap_req ();
  mem_req_if mem_q ();

  snes_bus_capture u_capture (
    .CLK, .rst_n,
    .snes_addr, .snes_pa, .snes_romsel, .snes_rd_n, .snes_wr_n, .snes_wdata,
    .mapper, .featurebits, .rom_mask, .saveram_mask,
    .cap (cap_req.producer),
    .msu_enable, .r213f_enable, .obc1_enable, .snescmd_enable,
    .nmicmd_enable, .return_vector_enable, .branch1_enable, .branch2_enable,
    .overflow
  );

  cfg_regs u_cfg (
    .CLK, .rst_n,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .overflow,
    .mapper, .featurebits, .rom_mask, .saveram_mask
  );

  req_fifo u_fifo (
    .CLK, .rst_n,
    .wr (cap_req.consumer),
    .rd (mem_q.producer)
  );

  mem_port u_mem_port (
    .CLK, .rst_n,
    .req (mem_q.consumer),
    .mem_req, .mem_addr, .mem_we, .mem_wdata, .mem_ack, .mem_rdata,
    .rd_valid, .rd_data, .rd_addr
  );

endmodule

// File: design/mem_port.sv
module mem_port
  import snes_map_pkg::*, snes_bus_pkg::*;
(
  input  logic       CLK,
  input  logic       rst_n,
  mem_req_if.consumer req,
  output logic       mem_req,
  output rom_addr_t  mem_addr,
  output logic       mem_we,
  output snes_data_t mem_wdata,
  input  logic       mem_ack,
  input  snes_data_t mem_rdata,
  output logic       rd_valid,
  output snes_data_t rd_data,
  output rom_addr_t  rd_addr
);

  typedef enum logic {st_idle, st_busy} port_state_e;

  port_state_e state;

  assign req.ready = (state == st_idle);
  assign mem_req   = (state == st_busy);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state    <= st_idle;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= 1'b0;
      case (state)
        st_idle: if (req.valid) state <= st_busy;
        st_busy: if (mem_ack) begin
          state    <= st_idle;
          rd_valid <= ~mem_we;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (req.valid && req.ready) begin
      mem_addr  <= req.addr;
      mem_we    <= req.write & req.saveram;  // Only save RAM takes writes
      mem_wdata <= req.wdata;
    end
    if (state == st_busy && mem_ack && !mem_we) begin
      rd_data <= mem_rdata;
      rd_addr <= mem_addr;
    end
  end

endmodule

// File: design/req_fifo.sv
module req_fifo
  import snes_map_pkg::*, snes_bus_pkg::*;
(
  input  logic CLK,
  input  logic rst_n,
  mem_req_if.consumer wr,
  mem_req_if.producer rd
);

  rom_addr_t  addr_mem    [REQ_FIFO_DEPTH];
  logic       write_mem   [REQ_FIFO_DEPTH];
  snes_data_t wdata_mem   [REQ_FIFO_DEPTH];
  logic       saveram_mem [REQ_FIFO_DEPTH];

  logic [REQ_PTR_W-1:0] wr_ptr;
  logic [REQ_PTR_W-1:0] rd_ptr;
  logic [REQ_CNT_W-1:0] count;
  logic                 push;
  logic                 pop;

  assign wr.ready = (count != REQ_CNT_W'(REQ_FIFO_DEPTH)) || rd.ready;  // Pass-through when full
  assign rd.valid = (count != '0);
  assign push     = wr.valid & wr.ready;
  assign pop      = rd.valid & rd.ready;

  // Head entry is visible without a read cycle
  assign rd.addr    = addr_mem[rd_ptr];
  assign rd.write   = write_mem[rd_ptr];
  assign rd.wdata   = wdata_mem[rd_ptr];
  assign rd.saveram = saveram_mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (push) begin
      addr_mem[wr_ptr]    <= wr.addr;
      write_mem[wr_ptr]   <= wr.write;
      wdata_mem[wr_ptr]   <= wr.wdata;
      saveram_mem[wr_ptr] <= wr.saveram;
    end
  end

endmodule

// File: design/cfg_regs.sv
module cfg_regs
  import snes_map_pkg::*, snes_bus_pkg::*;
(
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  apb_addr_t  paddr,
  input  apb_data_t  pwdata,
  output apb_data_t  prdata,
  output logic       pready,
  output logic       pslverr,
  input  logic       overflow,
  output mapper_e    mapper,
  output feature_t   featurebits,
  output addr_mask_t rom_mask,
  output addr_mask_t saveram_mask
);

  logic apb_wr;
  logic ovf_flag;

  assign pready  = 1'b1;  // Zero wait states
  assign pslverr = psel & penable & (paddr > REG_STATUS);
  assign apb_wr  = psel & penable & pwrite;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      mapper       <= map_lo;
      featurebits  <= '0;
      rom_mask     <= '0;
      saveram_mask <= '0;
      ovf_flag     <= 1'b0;
    end else begin
      if (apb_wr && paddr == REG_CTRL) begin
        mapper      <= mapper_e'(pwdata[2:0]);
        featurebits <= pwdata[15:8];
      end
      if (apb_wr && paddr == REG_ROM_MASK) begin
        rom_mask <= pwdata[23:0];
      end
      if (apb_wr && paddr == REG_SRAM_MASK) begin
        saveram_mask <= pwdata[23:0];
      end
      if (overflow) begin
        ovf_flag <= 1'b1;  // Set beats clear
      end else if (apb_wr && paddr == REG_STATUS && pwdata[0]) begin
        ovf_flag <= 1'b0;
      end
    end
  end

  always_comb begin
    case (paddr)
      REG_CTRL:      prdata = {16'b0, featurebits, 5'b0, mapper};
      REG_ROM_MASK:  prdata = {8'b0, rom_mask};
      REG_SRAM_MASK: prdata = {8'b0, saveram_mask};
      REG_STATUS:    prdata = {31'b0, ovf_flag};
      default:       prdata = '0;
    endcase
  end

endmodule

// File: address/snes_bus_capture.sv
module snes_bus_capture
  import snes_map_pkg::*, snes_bus_pkg::*;
(
  input  logic       CLK,
  input  logic       rst_n,
  input  snes_addr_t snes_addr,
  input  snes_data_t snes_pa,
  input  logic       snes_romsel,
  input  logic       snes_rd_n,
  input  logic       snes_wr_n,
  input  snes_data_t snes_wdata,
  input  mapper_e    mapper,
  input  feature_t   featurebits,
  input  addr_mask_t rom_mask,
  input  addr_mask_t saveram_mask,
  mem_req_if.producer cap,
  output logic       msu_enable,
  output logic       r213f_enable,
  output logic       obc1_enable,
  output logic       snescmd_enable,
  output logic       nmicmd_enable,
  output logic       return_vector_enable,
  output logic       branch1_enable,
  output logic       branch2_enable,
  output logic       overflow
);

  logic      rd_n_q;
  logic      wr_n_q;
  logic      rd_hit;
  logic      wr_hit;
  logic      req_hit;
  logic      cap_xfer;
  rom_addr_t dec_addr;
  logic      dec_rom_hit;
  logic      dec_saveram;
  logic      dec_writable;

  address_decode u_decode (
    .snes_addr            (snes_addr),
    .snes_pa              (snes_pa),
    .snes_romsel          (snes_romsel),
    .mapper               (mapper),
    .featurebits          (featurebits),
    .rom_mask             (rom_mask),
    .saveram_mask         (saveram_mask),
    .rom_addr             (dec_addr),
    .rom_hit              (dec_rom_hit),
    .is_saveram           (dec_saveram),
    .is_writable          (dec_writable),
    .msu_enable           (msu_enable),
    .r213f_enable         (r213f_enable),
    .obc1_enable          (obc1_enable),
    .snescmd_enable       (snescmd_enable),
    .nmicmd_enable        (nmicmd_enable),
    .return_vector_enable (return_vector_enable),
    .branch1_enable       (branch1_enable),
    .branch2_enable       (branch2_enable)
  );

  // Falling strobe edges that map somewhere
  assign rd_hit   = rd_n_q & ~snes_rd_n & dec_rom_hit;
  assign wr_hit   = wr_n_q & ~snes_wr_n & dec_writable;
  assign req_hit  = rd_hit | wr_hit;
  assign cap_xfer = cap.valid & cap.ready;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      rd_n_q    <= 1'b1;
      wr_n_q    <= 1'b1;
      cap.valid <= 1'b0;
      overflow  <= 1'b0;
    end else begin
      rd_n_q   <= snes_rd_n;
      wr_n_q   <= snes_wr_n;
      overflow <= req_hit & cap.valid & ~cap_xfer;  // Request lost
      if (cap_xfer) begin
        cap.valid <= 1'b0;
      end
      if (req_hit && (!cap.valid || cap_xfer)) begin
        cap.valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (req_hit && (!cap.valid || cap_xfer)) begin
      cap.addr    <= dec_addr;
      cap.write   <= ~rd_hit;
      cap.wdata   <= snes_wdata;
      cap.saveram <= dec_saveram;
    end
  end

endmodule

// File: address/address_decode.sv
module address_decode
  import snes_map_pkg::*, snes_bus_pkg::*;
(
  input  snes_addr_t snes_addr,
  input  snes_data_t snes_pa,
  input  logic       snes_romsel,
  input  mapper_e    mapper,
  input  feature_t   featurebits,
  input  addr_mask_t rom_mask,
  input  addr_mask_t saveram_mask,
  output rom_addr_t  rom_addr,
  output logic       rom_hit,
  output logic       is_saveram,
  output logic       is_writable,
  output logic       msu_enable,
  output logic       r213f_enable,
  output logic       obc1_enable,
  output logic       snescmd_enable,
  output logic       nmicmd_enable,
  output logic       return_vector_enable,
  output logic       branch1_enable,
  output logic       branch2_enable
);

  logic       map_valid;
  logic       is_rom;
  logic       lo_sram;    // Banks 20-3F/A0-BF, 6000-7FFF
  logic       hi_sram;    // Banks 70-7F
  rom_addr_t  sram_off;
  rom_addr_t  rom_part;

  assign map_valid = (mapper == map_lo) || (mapper == map_hi) || (mapper == map_ex);
  assign is_rom    = map_valid & (snes_addr[22] | snes_addr[15]);

  assign lo_sram = ~snes_addr[22] & snes_addr[21] & (&snes_addr[14:13]) & ~snes_addr[15];
  assign hi_sram = (&snes_addr[22:20]) & ~snes_romsel & (~snes_addr[15] | ~rom_mask[21]);

  always_comb begin
    is_saveram = 1'b0;
    sram_off   = '0;
    rom_part   = '0;
    case (mapper)
      map_lo: begin
        is_saveram = lo_sram;
        sram_off   = {6'b0, snes_addr[20:16], snes_addr[12:0]};
        rom_part   = {1'b0, snes_addr[22:0]};
      end
      map_hi: begin
        is_saveram = hi_sram;
        sram_off   = {4'b0, snes_addr[20:16], snes_addr[14:0]};
        rom_part   = {2'b00, snes_addr[22:16], snes_addr[14:0]};
      end
      map_ex: begin
        is_saveram = lo_sram;
        sram_off   = {6'b0, snes_addr[20:16], snes_addr[12:0]};
        rom_part   = {1'b0, ~snes_addr[23], snes_addr[21:0]};  // Upper 4MB first
      end
      default: ;
    endcase
    is_saveram = is_saveram & saveram_mask[0];  // No save RAM if mask is empty
  end

  assign rom_addr    = is_saveram ? SAVERAM_BASE + (sram_off & saveram_mask)
                                  : (rom_part & rom_mask);
  assign is_writable = is_saveram;
  assign rom_hit     = is_rom | is_writable;

  assign msu_enable   = featurebits[FEAT_MSU1] & ~snes_addr[22]
                        & ((snes_addr[15:0] & 16'hfff8) == 16'h2000);
  assign r213f_enable = featurebits[FEAT_213F] & (snes_pa == 8'h3f);
  assign obc1_enable  = ~snes_addr[22] & (snes_addr[15:11] == 5'b01111);

  assign snescmd_enable       = ({snes_addr[22], snes_addr[15:9]} == 8'b0_0010101);
  assign nmicmd_enable        = (snes_addr == NMICMD_ADDR);
  assign return_vector_enable = (snes_addr == RETVEC_ADDR);
  assign branch1_enable       = (snes_addr == BRANCH1_ADDR);
  assign branch2_enable       = (snes_addr == BRANCH2_ADDR);

endmodule

// File: common/mem_req_if.sv
interface mem_req_if
  import snes_map_pkg::*, snes_bus_pkg::*;
();

  logic       valid;
  logic       ready;
  rom_addr_t  addr;
  logic       write;
  snes_data_t wdata;
  logic       saveram;

  modport producer (
    output valid, addr, write, wdata, saveram,
    input  ready
  );

  modport consumer (
    input  valid, addr, write, wdata, saveram,
    output ready
  );

endinterface

// File: common/snes_bus_pkg.sv
package snes_bus_pkg;

  typedef logic [7:0]  snes_data_t;
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  localparam int REQ_FIFO_DEPTH = 4;
  localparam int REQ_PTR_W      = $clog2(REQ_FIFO_DEPTH);
  localparam int REQ_CNT_W      = $clog2(REQ_FIFO_DEPTH + 1);

  localparam apb_addr_t REG_CTRL      = 8'h00;  // Mapper 2:0, features 15:8
  localparam apb_addr_t REG_ROM_MASK  = 8'h04;
  localparam apb_addr_t REG_SRAM_MASK = 8'h08;
  localparam apb_addr_t REG_STATUS    = 8'h0C;  // Bit 0 overflow, write 1 to clear

endpackage

// File: common/snes_map_pkg.sv
package snes_map_pkg;

  typedef logic [23:0] snes_addr_t;
  typedef logic [23:0] rom_addr_t;
  typedef logic [23:0] addr_mask_t;
  typedef logic [7:0]  feature_t;

  typedef enum logic [2:0] {
    map_lo = 3'd0,
    map_hi = 3'd1,
    map_ex = 3'd2
  } mapper_e;

  // Bit positions in featurebits
  localparam int FEAT_MSU1 = 3;
  localparam int FEAT_213F = 4;

  localparam rom_addr_t SAVERAM_BASE = 24'hE00000;  // Save RAM window in memory

  // Patch hooks in the command area
  localparam snes_addr_t NMICMD_ADDR  = 24'h002BF2;
  localparam snes_addr_t RETVEC_ADDR  = 24'h002A5A;
  localparam snes_addr_t BRANCH1_ADDR = 24'h002A13;
  localparam snes_addr_t BRANCH2_ADDR = 24'h002A4D;

endpackage
